// ==== logic/clockEdit_params.svh ====
// Field count, cursor range, event FIFO depth and APB register map macros
`ifndef CLOCKEDIT_PARAMS_SVH
`define CLOCKEDIT_PARAMS_SVH

////////////////////////////////////////
// Field bank

// Day, month, year, hour, minute, second, timer hour, timer minute, timer second
`define CE_NUM_FIELDS 9

// Two digits per field, tens on even positions
`define CE_CURSOR_MAX 17

////////////////////////////////////////
// Event queue

`define CE_FIFO_DEPTH 4

////////////////////////////////////////
// Register map

// Word index is byte address / 4, fields sit at indexes 0 to 8
`define CE_ADDR_STATUS 9

`endif

// ==== logic/clockEditPkg.sv ====
// Edit event enum, BCD field union, button/status/load/APB structs and tens digit limits
`default_nettype none

`include "clockEdit_params.svh"

package clockEditPkg;

	typedef enum logic [2:0] {
		evCursorUp,
		evCursorDown,
		evDigitInc,
		evDigitDec,
		evModeToggle
	} editEvent_t;

	typedef struct packed {
		logic up;
		logic down;
		logic next;
		logic previous;
		logic modify;
	} buttonPins_t;

	////////////////////////////////////////
	// One field byte, seen as BCD digits or as a raw byte

	typedef struct packed {
		logic [3:0] tens;
		logic [3:0] ones;
	} bcdDigits_t;

	typedef union packed {
		logic [7:0] raw;
		bcdDigits_t digits;
	} bcdField_u;

	typedef bcdField_u [`CE_NUM_FIELDS-1:0] fieldBank_t;

	typedef struct packed {
		logic       editMode;
		logic [4:0] cursor;
	} editStatus_t;

	typedef struct packed {
		logic       valid;
		logic [3:0] index;
		bcdField_u  value;
	} fieldLoad_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [7:0]  paddr;
		logic [31:0] pwdata;
	} apbReq_t;

	typedef struct packed {
		logic        pready;
		logic        pslverr;
		logic [31:0] prdata;
	} apbRsp_t;

	// Highest tens digit per field, the ones digit always tops out at 9
	function automatic logic [3:0] tensLimit(input logic [3:0] index);
		case (index)
			4'd0:    return 4'd3; // Day
			4'd1:    return 4'd1; // Month
			4'd3,
			4'd6:    return 4'd2; // Hour, timer hour
			4'd4, 4'd5,
			4'd7, 4'd8: return 4'd5;
			default: return 4'd9; // Year
		endcase
	endfunction

endpackage

`default_nettype wire

// ==== logic/buttonSync.sv ====
// buttonSync module with button synchronizer, rising edge detect and prioritized pending presses
`timescale 1ns/10ps
`default_nettype none

module buttonSync (
	input  logic                      BanderaUP,
	input  logic                      BanderaDOWN,
	input  clockEditPkg::buttonPins_t buttons,
	input  logic                      full,
	output logic                      push,
	output clockEditPkg::editEvent_t  pushEvent
);
	import clockEditPkg::*;

	buttonPins_t syncMeta;   // First stage, may go metastable
	buttonPins_t syncStable; // Second stage
	buttonPins_t syncPrev;   // Edge history
	buttonPins_t rise;
	buttonPins_t pending;    // Presses waiting for FIFO space
	buttonPins_t grant;
	buttonPins_t clearMask;

	////////////////////////////////////////
	// Synchronizer and edge detect
	always_ff @(posedge BanderaUP or posedge BanderaDOWN) begin
		if (BanderaDOWN) begin
			syncMeta   <= '0;
			syncStable <= '0;
			syncPrev   <= '0;
		end else begin
			syncMeta   <= buttons;
			syncStable <= syncMeta;
			syncPrev   <= syncStable;
		end
	end

	assign rise = syncStable & ~syncPrev;

	////////////////////////////////////////
	// Pick one press per cycle, fixed order
	always_comb begin
		grant     = '0;
		pushEvent = evCursorUp;
		if (pending.up) begin
			grant.up  = 1'b1;
			pushEvent = evCursorUp;
		end else if (pending.down) begin
			grant.down = 1'b1;
			pushEvent  = evCursorDown;
		end else if (pending.next) begin
			grant.next = 1'b1;
			pushEvent  = evDigitInc;
		end else if (pending.previous) begin
			grant.previous = 1'b1;
			pushEvent      = evDigitDec;
		end else if (pending.modify) begin
			grant.modify = 1'b1;
			pushEvent    = evModeToggle;
		end
	end

	assign push      = (|pending) && !full;
	assign clearMask = push ? grant : '0;

	// A repeat press while its bit is still set merges into it
	always_ff @(posedge BanderaUP or posedge BanderaDOWN) begin
		if (BanderaDOWN)
			pending <= '0;
		else
			pending <= (pending & ~clearMask) | rise;
	end

endmodule

`default_nettype wire

// ==== logic/eventFifo.sv ====
// eventFifo module, circular queue of edit events with combinational head
`timescale 1ns/10ps
`default_nettype none

`include "clockEdit_params.svh"

module eventFifo (
	input  logic                     BanderaUP,
	input  logic                     BanderaDOWN,
	input  logic                     push,
	input  clockEditPkg::editEvent_t pushEvent,
	input  logic                     pop,
	output logic                     full,
	output logic                     empty,
	output clockEditPkg::editEvent_t headEvent
);
	import clockEditPkg::*;

	localparam int Depth  = `CE_FIFO_DEPTH;
	localparam int PtrW   = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountW = $clog2(Depth + 1);

	editEvent_t        queue [Depth];
	logic [PtrW-1:0]   rdPtr;
	logic [PtrW-1:0]   wrPtr;
	logic [CountW-1:0] count;
	logic              doPush;
	logic              doPop;

	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
		return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full      = (count == CountW'(Depth));
	assign empty     = (count == '0);
	assign doPush    = push && !full;
	assign doPop     = pop && !empty;
	assign headEvent = queue[rdPtr]; // Head shown before the pop

	always_ff @(posedge BanderaUP) begin
		if (doPush)
			queue[wrPtr] <= pushEvent;
	end

	////////////////////////////////////////
	// Pointers and occupancy
	always_ff @(posedge BanderaUP or posedge BanderaDOWN) begin
		if (BanderaDOWN) begin
			rdPtr <= '0;
			wrPtr <= '0;
			count <= '0;
		end else begin
			if (doPush) wrPtr <= nextPtr(wrPtr);
			if (doPop) rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/fieldEditor.sv ====
// fieldEditor module holding cursor, edit mode and BCD fields, applying events and host loads
`timescale 1ns/10ps
`default_nettype none

`include "clockEdit_params.svh"

module fieldEditor (
	input  logic                      BanderaUP,
	input  logic                      BanderaDOWN,
	input  logic                      empty,
	input  clockEditPkg::editEvent_t  headEvent,
	input  clockEditPkg::fieldLoad_t  load,
	output logic                      pop,
	output clockEditPkg::fieldBank_t  fields,
	output clockEditPkg::editStatus_t status
);
	import clockEditPkg::*;

	localparam logic [4:0] CursorMax = 5'(`CE_CURSOR_MAX);

	fieldBank_t  fieldsQ;
	editStatus_t statusQ;

	logic [3:0] selIndex;  // Field under the cursor
	logic       selTens;   // Even cursor picks the tens digit
	bcdField_u  selField;
	logic [3:0] digit;
	logic [3:0] limit;
	logic [3:0] incDigit;
	logic [3:0] decDigit;
	bcdField_u  incField;
	bcdField_u  decField;
	logic [4:0] cursorUp;
	logic [4:0] cursorDown;

	// Host load wins the cycle, the event waits in the FIFO
	assign pop = !empty && !load.valid;

	assign fields = fieldsQ;
	assign status = statusQ;

	////////////////////////////////////////
	// Cursor wrap
	assign cursorUp   = (statusQ.cursor == CursorMax) ? 5'd0 : statusQ.cursor + 5'd1;
	assign cursorDown = (statusQ.cursor == 5'd0) ? CursorMax : statusQ.cursor - 5'd1;

	////////////////////////////////////////
	// Selected digit and its stepped values
	assign selIndex = statusQ.cursor[4:1];
	assign selTens  = !statusQ.cursor[0];
	assign selField = fieldsQ[selIndex];

	always_comb begin
		digit = selTens ? selField.digits.tens : selField.digits.ones;
		limit = selTens ? tensLimit(selIndex) : 4'd9;

		// Out of range digits fold back into range
		if (digit >= limit)
			incDigit = 4'd0;
		else
			incDigit = digit + 4'd1;

		if (digit == 4'd0 || digit > limit)
			decDigit = limit;
		else
			decDigit = digit - 4'd1;

		incField = selField;
		decField = selField;
		if (selTens) begin
			incField.digits.tens = incDigit;
			decField.digits.tens = decDigit;
		end else begin
			incField.digits.ones = incDigit;
			decField.digits.ones = decDigit;
		end
	end

	////////////////////////////////////////
	// State update
	always_ff @(posedge BanderaUP or posedge BanderaDOWN) begin
		if (BanderaDOWN) begin
			fieldsQ <= '0;
			statusQ <= '0;
		end else if (load.valid) begin
			fieldsQ[load.index] <= load.value; // Whole byte, no digit check
		end else if (pop) begin
			case (headEvent)
				evCursorUp:   statusQ.cursor <= cursorUp;
				evCursorDown: statusQ.cursor <= cursorDown;
				evDigitInc: begin
					if (statusQ.editMode)
						fieldsQ[selIndex] <= incField;
				end
				evDigitDec: begin
					if (statusQ.editMode)
						fieldsQ[selIndex] <= decField;
				end
				evModeToggle: statusQ.editMode <= !statusQ.editMode;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/apbRegPort.sv ====
// apbRegPort module, APB slave decoding field reads, field loads and status reads
`timescale 1ns/10ps
`default_nettype none

`include "clockEdit_params.svh"

module apbRegPort (
	input  logic                      BanderaUP,
	input  logic                      BanderaDOWN,
	input  clockEditPkg::apbReq_t     apbReq,
	input  clockEditPkg::fieldBank_t  fields,
	input  clockEditPkg::editStatus_t status,
	output clockEditPkg::apbRsp_t     apbRsp,
	output clockEditPkg::fieldLoad_t  load
);
	import clockEditPkg::*;

	localparam logic [5:0] StatusIndex = 6'(`CE_ADDR_STATUS);
	localparam logic [5:0] NumFields   = 6'(`CE_NUM_FIELDS);

	logic [5:0] wordIndex;
	logic       setupDone; // Setup phase seen on the last edge
	logic       access;
	logic       fieldHit;
	logic       badAccess;

	assign wordIndex = apbReq.paddr[7:2];
	assign fieldHit  = (wordIndex < NumFields);

	////////////////////////////////////////
	// Phase tracking
	always_ff @(posedge BanderaUP or posedge BanderaDOWN) begin
		if (BanderaDOWN)
			setupDone <= 1'b0;
		else
			setupDone <= apbReq.psel && !apbReq.penable;
	end

	// Zero wait states, ready in every access phase
	assign access = apbReq.psel && apbReq.penable && setupDone;

	// Status is read only
	assign badAccess = (wordIndex > StatusIndex) ||
		(apbReq.pwrite && (wordIndex == StatusIndex));

	////////////////////////////////////////
	// Response
	always_comb begin
		apbRsp.pready  = access;
		apbRsp.pslverr = access && badAccess;
		apbRsp.prdata  = '0;
		if (access && !apbReq.pwrite) begin
			if (fieldHit)
				apbRsp.prdata[7:0] = fields[wordIndex[3:0]].raw;
			else if (wordIndex == StatusIndex)
				apbRsp.prdata[5:0] = status; // Mode on bit 5, cursor below
		end
	end

	////////////////////////////////////////
	// Field load, applied on the edge ending the access
	always_comb begin
		load.valid     = access && apbReq.pwrite && fieldHit;
		load.index     = wordIndex[3:0];
		load.value.raw = apbReq.pwdata[7:0];
	end

endmodule

`default_nettype wire

// ==== logic/clockEditTop.sv ====
// clockEditTop module connecting button sync, event FIFO, field editor and APB port
`timescale 1ns/10ps
`default_nettype none

module clockEditTop (
	input  logic                      BanderaUP,
	input  logic                      BanderaDOWN,
	input  clockEditPkg::buttonPins_t buttons,
	input  clockEditPkg::apbReq_t     apbReq,
	output clockEditPkg::apbRsp_t     apbRsp
);
	import clockEditPkg::*;

	////////////////////////////////////////
	// Producer to queue
	logic       push;
	logic       full;
	editEvent_t pushEvent;

	////////////////////////////////////////
	// Queue to editor
	logic       pop;
	logic       empty;
	editEvent_t headEvent;

	////////////////////////////////////////
	// Host port and editor
	fieldLoad_t  load;
	fieldBank_t  fields;
	editStatus_t status;

	buttonSync uButtonSync (
		.BanderaUP   (BanderaUP),
		.BanderaDOWN (BanderaDOWN),
		.buttons     (buttons),
		.full        (full),
		.push        (push),
		.pushEvent   (pushEvent)
	);

	eventFifo uEventFifo (
		.BanderaUP   (BanderaUP),
		.BanderaDOWN (BanderaDOWN),
		.push        (push),
		.pushEvent   (pushEvent),
		.pop         (pop),
		.full        (full),
		.empty       (empty),
		.headEvent   (headEvent)
	);

	fieldEditor uFieldEditor (
		.BanderaUP   (BanderaUP),
		.BanderaDOWN (BanderaDOWN),
		.empty       (empty),
		.headEvent   (headEvent),
		.load        (load),
		.pop         (pop),
		.fields      (fields),
		.status      (status)
	);

	apbRegPort uApbRegPort (
		.BanderaUP   (BanderaUP),
		.BanderaDOWN (BanderaDOWN),
		.apbReq      (apbReq),
		.fields      (fields),
		.status      (status),
		.apbRsp      (apbRsp),
		.load        (load)
	);

endmodule

`default_nettype wire

// ==== tests/clockEditSva.sv ====
// clockEditSva assertions on APB response and event FIFO rules, plus its bind to clockEditTop
`timescale 1ns/10ps
`default_nettype none

module clockEditSva (
	input logic                  BanderaUP,
	input logic                  BanderaDOWN,
	input clockEditPkg::apbReq_t apbReq,
	input clockEditPkg::apbRsp_t apbRsp,
	input logic                  push,
	input logic                  full,
	input logic                  pop,
	input logic                  empty
);

	////////////////////////////////////////
	// APB response
	readyInAccess: assert property (@(posedge BanderaUP) disable iff (BanderaDOWN)
		apbRsp.pready |-> (apbReq.psel && apbReq.penable))
		else $error("pready raised outside an access phase");

	errorWithReady: assert property (@(posedge BanderaUP) disable iff (BanderaDOWN)
		apbRsp.pslverr |-> apbRsp.pready)
		else $error("pslverr raised without pready");

	////////////////////////////////////////
	// Event queue
	noPushWhenFull: assert property (@(posedge BanderaUP) disable iff (BanderaDOWN)
		push |-> !full)
		else $error("push while the event FIFO is full");

	noPopWhenEmpty: assert property (@(posedge BanderaUP) disable iff (BanderaDOWN)
		pop |-> !empty)
		else $error("pop while the event FIFO is empty");

endmodule

bind clockEditTop clockEditSva uClockEditSva (
	.BanderaUP   (BanderaUP),
	.BanderaDOWN (BanderaDOWN),
	.apbReq      (apbReq),
	.apbRsp      (apbRsp),
	.push        (push),
	.full        (full),
	.pop         (pop),
	.empty       (empty)
);

`default_nettype wire

// ==== tests/clockEditTb.sv ====
// clockEditTb testbench with clock, reset, watchdog, button and APB tasks, reference model, checks
`timescale 1ns/10ps
`default_nettype none

`include "clockEdit_params.svh"

module clockEditTb;
	import clockEditPkg::*;

	// Button codes follow the struct order, up on the top bit
	localparam int BtnUp     = 0;
	localparam int BtnDown   = 1;
	localparam int BtnNext   = 2;
	localparam int BtnPrev   = 3;
	localparam int BtnModify = 4;

	// About 30 presses of 14 cycles and 140 transfers of 3 cycles, plus reset and drain
	localparam int WorstCycles = 8 + 30 * 14 + 140 * 3 + 40;

	// Highest tens digit: day, month, year, hour, minute, second, timer h/m/s
	localparam logic [3:0] TensTable [`CE_NUM_FIELDS] = '{3, 1, 9, 2, 5, 5, 2, 5, 5};

	logic        BanderaUP;
	logic        BanderaDOWN;
	buttonPins_t buttons;
	apbReq_t     apbReq;
	apbRsp_t     apbRsp;
	integer      seed;
	int          errorCount;
	int          checkCount;
	logic [7:0]  modelField [`CE_NUM_FIELDS];
	logic [4:0]  modelCursor;
	logic        modelMode;

	clockEditTop UUT (
		.BanderaUP   (BanderaUP),
		.BanderaDOWN (BanderaDOWN),
		.buttons     (buttons),
		.apbReq      (apbReq),
		.apbRsp      (apbRsp)
	);

	always #10 BanderaUP = ~BanderaUP; // 20 ns period

	initial begin
		#(WorstCycles * 30); // 1.5 times the worst case at 20 ns a cycle
		$display("Timeout: the tests did not finish within %0d ns", WorstCycles * 30);
		$display("*** TEST FAILED ***");
		$finish;
	end

	task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			$display("Mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
		end
	endtask

	task automatic nextCycle;
		@(posedge BanderaUP);
		#2;
	endtask

	////////////////////////////////////////
	// APB transfers
	task automatic apbXfer(input logic write, input int index, input logic [7:0] wdata,
			output logic [31:0] rdata, output logic err);
		apbReq.psel    = 1'b1;
		apbReq.penable = 1'b0;
		apbReq.pwrite  = write;
		apbReq.paddr   = 8'(index * 4);
		apbReq.pwdata  = {24'd0, wdata};
		@(negedge BanderaUP);
		checkValue({apbRsp.pready, apbRsp.pslverr}, 0, "pready/pslverr in setup phase");
		nextCycle();
		apbReq.penable = 1'b1;
		@(negedge BanderaUP);
		// No wait states, ready in the first access cycle
		checkValue(apbRsp.pready, 1, $sformatf("pready in access to index %0d", index));
		rdata = apbRsp.prdata;
		err   = apbRsp.pslverr;
		nextCycle();
		apbReq = '0;
	endtask

	task automatic apbWrite(input int index, input logic [7:0] data, input logic expErr);
		logic [31:0] rdata;
		logic        err;
		apbXfer(1'b1, index, data, rdata, err);
		checkValue(err, expErr, $sformatf("pslverr on write to index %0d", index));
	endtask

	task automatic apbRead(input int index, output logic [31:0] data, output logic err);
		apbXfer(1'b0, index, 8'h00, data, err);
	endtask

	////////////////////////////////////////
	// Reference model of cursor, mode and digits
	function automatic void modelPress(input int btn);
		int         idx;
		logic       tens;
		logic [3:0] digit;
		logic [3:0] lim;
		idx   = int'(modelCursor >> 1);
		tens  = !modelCursor[0];
		digit = tens ? modelField[idx][7:4] : modelField[idx][3:0];
		lim   = tens ? TensTable[idx] : 4'd9;
		case (btn)
			BtnUp:     modelCursor = (modelCursor == `CE_CURSOR_MAX) ? 5'd0 : modelCursor + 5'd1;
			BtnDown:   modelCursor = (modelCursor == 5'd0) ? 5'(`CE_CURSOR_MAX) : modelCursor - 5'd1;
			BtnModify: modelMode = !modelMode;
			BtnNext:   digit = (digit >= lim) ? 4'd0 : digit + 4'd1;
			BtnPrev:   digit = (digit == 4'd0 || digit > lim) ? lim : digit - 4'd1;
			default: ;
		endcase
		if (modelMode && (btn == BtnNext || btn == BtnPrev)) begin
			if (tens)
				modelField[idx][7:4] = digit;
			else
				modelField[idx][3:0] = digit;
		end
	endfunction

	task automatic pressButton(input int btn);
		buttons = buttonPins_t'(5'b10000 >> btn);
		repeat (3) nextCycle();
		buttons = '0;
		repeat (11) nextCycle(); // 3 low, then 8 idle
		modelPress(btn);
	endtask

	task automatic moveCursor(input int target);
		while (int'(modelCursor) != target)
			pressButton((target < int'(modelCursor)) ? BtnDown : BtnUp);
	endtask

	task automatic checkStatus(input string tag);
		logic [31:0] data;
		logic        err;
		apbRead(`CE_ADDR_STATUS, data, err);
		checkValue(data, {26'd0, modelMode, modelCursor}, {tag, ": status"});
	endtask

	task automatic checkAll(input string tag);
		logic [31:0] data;
		logic        err;
		for (int i = 0; i < `CE_NUM_FIELDS; i++) begin
			apbRead(i, data, err);
			checkValue(data, {24'd0, modelField[i]}, $sformatf("%s: field %0d", tag, i));
			checkValue(err, 0, $sformatf("%s: pslverr on field %0d", tag, i));
		end
		checkStatus(tag);
	endtask

	////////////////////////////////////////
	// Directed tests
	task automatic verifyResetState;
		@(negedge BanderaUP);
		checkValue({apbRsp.pready, apbRsp.pslverr}, 0, "idle after reset");
		nextCycle();
		checkAll("reset");
	endtask

	task automatic loadAndReadBack;
		logic [31:0] data;
		logic        err;
		for (int i = 0; i < `CE_NUM_FIELDS; i++) begin // Random BCD loads
			data          = $random(seed);
			modelField[i] = {4'(data[7:4] % 10), 4'(data[3:0] % 10)};
			apbWrite(i, modelField[i], 1'b0);
		end
		checkAll("load");
		apbWrite(10, 8'h55, 1'b1);
		apbWrite(`CE_ADDR_STATUS, 8'h3f, 1'b1);
		apbRead(10, data, err);
		checkValue(err, 1, "pslverr on read of index 10");
		checkAll("after rejected writes");
	endtask

	task automatic cursorWrap;
		pressButton(BtnDown);
		checkStatus("down from 0");
		pressButton(BtnUp);
		checkStatus("up from 17");
		repeat (6) pressButton(BtnUp);
		checkStatus("six ups");
	endtask

	task automatic digitEditing;
		logic [31:0] data;
		logic        err;
		for (int i = 0; i < `CE_NUM_FIELDS; i++) begin
			modelField[i] = 8'h00;
			apbWrite(i, 8'h00, 1'b0);
		end
		pressButton(BtnNext);
		pressButton(BtnPrev);
		checkAll("edit mode off");
		pressButton(BtnModify);
		moveCursor(2);
		pressButton(BtnNext);
		apbRead(1, data, err);
		checkValue(data, 32'h10, "month tens 0 to 1");
		pressButton(BtnNext);
		apbRead(1, data, err);
		checkValue(data, 32'h00, "month tens 1 to 0");
		moveCursor(3);
		pressButton(BtnPrev);
		apbRead(1, data, err);
		checkValue(data, 32'h09, "month ones 0 to 9");
		modelField[0] = 8'h70;
		apbWrite(0, 8'h70, 1'b0);
		moveCursor(0);
		pressButton(BtnNext);
		apbRead(0, data, err);
		checkValue(data, 32'h00, "day tens 7 to 0");
		checkAll("edit mode on");
	endtask

	// Burst on day ones with a host load in between
	task automatic eventBurst;
		moveCursor(1);
		fork
			repeat (8) begin
				buttons.next = 1'b1;
				nextCycle();
				buttons.next = 1'b0;
				nextCycle();
				modelPress(BtnNext);
			end
			begin
				repeat (7) nextCycle();
				modelField[5] = 8'h42;
				apbWrite(5, 8'h42, 1'b0);
			end
		join
		repeat (8) nextCycle();
		checkAll("burst");
	endtask

	initial begin
		seed        = 75;
		errorCount  = 0;
		checkCount  = 0;
		BanderaUP   = 1'b0;
		BanderaDOWN = 1'b1;
		buttons     = '0;
		apbReq      = '0;
		modelCursor = '0;
		modelMode   = 1'b0;
		modelField  = '{default: 8'h00};
		repeat (8) @(posedge BanderaUP);
		#2;
		BanderaDOWN = 1'b0;

		verifyResetState();
		loadAndReadBack();
		cursorWrap();
		digitEditing();
		eventBurst();

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== clockEditTop.f ====
+incdir+logic
logic/clockEditPkg.sv
logic/buttonSync.sv
logic/eventFifo.sv
logic/fieldEditor.sv
logic/apbRegPort.sv
logic/clockEditTop.sv
tests/clockEditSva.sv
tests/clockEditTb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = clockEditTb
FILELIST  = clockEditTop.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
